/* cpu_bus_pkg.sv */
// shared bus types, region codes and timing constants, imported by every block of the bus subsystem
package cpu_bus_pkg;

    // one cpu bus cycle as seen by the timing logic
    typedef struct packed {
        logic        as_n;  // address strobe, active low
        logic        rw;    // 1 = read
        logic [23:1] addr;  // word address, 68000 style
        logic [15:0] wdata; // write data, stable while as_n low
    } cpu_bus_t;

    // decode result; both bits low means local i/o
    typedef struct packed {
        logic mem_cs;   // slow shared memory
        logic qs_cs;    // sound cpu window
    } sel_t;

    // region codes on addr[23:20]
    localparam logic [3:0] MEM_BASE = 4'h0;
    localparam logic [3:0] QS_BASE  = 4'hf;

    // shared memory model
    localparam int MEM_AW         = 8;     // 256 words
    localparam int MEM_LAT        = 4;     // cycles of bus_busy per access
    localparam int LAT_W          = $clog2(MEM_LAT);
    localparam int REFRESH_PERIOD = 64;    // cycles between refresh windows
    localparam int REFRESH_LEN    = 6;     // cycles the array is blocked
    localparam int REF_W          = $clog2(REFRESH_PERIOD);

    // stall recovery
    localparam int FAIL_STEP = 3;   // added per lost cen16
    localparam int FAIL_W    = 6;

    // grant synchronizer depth
    localparam int SYNC_STAGES = 2;

endpackage

/* bus_region_decode.sv */
// decodes the strobed cpu address into shared memory and sound window chip selects
`timescale 1ns/10ps

module bus_region_decode import cpu_bus_pkg::*; (
    input  cpu_bus_t cpu,
    output sel_t     sel
);

    logic       active;     // strobe asserted
    logic [3:0] region;     // top address nibble

    assign active = ~cpu.as_n;
    assign region = cpu.addr[23:20];

    // idle bus selects nothing, anything not matched is local i/o
    always_comb begin
        sel        = '0;
        if (active) begin
            sel.mem_cs = region == MEM_BASE;
            sel.qs_cs  = region == QS_BASE;
        end
    end

endmodule

/* mem_port.sv */
// slow shared memory model with fixed latency and periodic refresh, reporting a busy level to the bus
`timescale 1ns/10ps

module mem_port import cpu_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  cpu_bus_t    cpu,
    input  logic        mem_cs,     // strobed memory select from decode
    output logic        bus_busy,
    output logic [15:0] rdata
);

    logic              last_as_n;
    logic [REF_W-1:0]  ref_cnt;     // phase within the refresh period
    logic [LAT_W-1:0]  lat_cnt;     // access cycles done
    logic              refresh;     // array blocked
    logic              req;
    logic              done;
    logic [MEM_AW-1:0] word_addr;
    logic [15:0]       mem [0:(1 << MEM_AW) - 1];

    assign refresh   = ref_cnt < REF_W'(REFRESH_LEN);  // first cycles of each period
    assign req       = mem_cs & last_as_n;              // only on the falling strobe
    assign done      = bus_busy & ~refresh & (lat_cnt == LAT_W'(MEM_LAT - 1));
    assign word_addr = cpu.addr[MEM_AW:1];              // cpu holds addr through the cycle

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            last_as_n <= 1'b1;
            ref_cnt   <= '0;
            lat_cnt   <= '0;
            bus_busy  <= 1'b0;
        end else begin
            last_as_n <= cpu.as_n;
            ref_cnt   <= (ref_cnt == REF_W'(REFRESH_PERIOD - 1)) ? '0 : ref_cnt + 1'b1;
            if (req) begin
                bus_busy <= 1'b1;
                lat_cnt  <= '0;
            end else if (bus_busy && !refresh) begin  // latency frozen during refresh
                lat_cnt <= lat_cnt + 1'b1;
                if (done) begin
                    bus_busy <= 1'b0;
                end
            end
        end
    end

    // array access lands on the cycle busy drops
    always_ff @(posedge clk) begin
        if (done) begin
            if (cpu.rw) begin
                rdata <= mem[word_addr];
            end else begin
                mem[word_addr] <= cpu.wdata;
            end
        end
    end

endmodule

/* qs_grant_sync.sv */
// requests the sound cpu bus during sound window cycles and brings the returned grant into clk
`timescale 1ns/10ps

module qs_grant_sync import cpu_bus_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic as_n,
    input  logic qs_cs,
    input  logic qs_busak_n,    // from the sound side, not related to clk
    output logic qs_busrq_n,
    output logic qs_busakn_s
);

    logic [SYNC_STAGES-1:0] sync;   // grant shift chain, idle high

    assign qs_busakn_s = sync[SYNC_STAGES-1];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            qs_busrq_n <= 1'b1;
            sync       <= '1;
        end else begin
            qs_busrq_n <= ~(qs_cs & ~as_n);    // drop request with the strobe
            sync       <= {sync[SYNC_STAGES-2:0], qs_busak_n};
        end
    end

endmodule

/* bus_dtack.sv */
// generates DTACKn per bus cycle and the cen16/cen16b enables, shortening the period to recover stalls
`timescale 1ns/10ps

module bus_dtack import cpu_bus_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic as_n,          // cpu address strobe
    input  logic bus_cs,        // cycle goes to shared memory
    input  logic bus_busy,      // memory still working
    input  logic qs_cs,         // cycle goes to sound window
    input  logic qs_busakn_s,   // synchronized sound bus grant, active low
    output logic DTACKn,
    output logic cen16,
    output logic cen16b
);

    logic [1:0]        cen_cnt;     // divider phase
    logic              last_as_n;   // strobe one cycle back
    logic              s3_over;     // first cen of the cycle already passed
    logic [FAIL_W-1:0] fail_cnt;    // lost enables still to pay back
    logic              recover;
    logic              cnt_over;
    logic              short_wrap;
    logic              hold_hi;
    logic              stall_hit;

    // pay back only when the cpu is not waiting on us
    assign recover = (as_n | ~DTACKn) & (fail_cnt != '0);

    // wrap at 2 while recovering, at 3 otherwise
    // >= keeps a late switch into recovery from running past the wrap
    assign cnt_over   = recover ? (cen_cnt >= 2'd1) : (cen_cnt >= 2'd2);
    assign short_wrap = recover & (cen_cnt == 2'd1);  // one cycle saved

    // idle strobe, falling-edge cycle, or sound window without grant
    assign hold_hi = as_n | last_as_n | (qs_cs & qs_busakn_s);

    // an enable lost to a memory stall after the cycle's first cen
    assign stall_hit = ~as_n & bus_cs & bus_busy & s3_over & cen16;

    // clock enable divider
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cen_cnt <= 2'd0;
            cen16   <= 1'b0;
            cen16b  <= 1'b0;
        end else begin
            cen_cnt <= cnt_over ? 2'd0 : cen_cnt + 2'd1;
            cen16   <= cen_cnt == 2'd0;
            cen16b  <= cen_cnt == 2'd1;    // always the cycle after cen16
        end
    end

    // strobe tracking and acknowledge
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            last_as_n <= 1'b1;
            DTACKn    <= 1'b1;
            s3_over   <= 1'b0;
        end else begin
            last_as_n <= as_n;
            if (hold_hi) begin
                DTACKn  <= 1'b1;
                s3_over <= 1'b0;
            end else begin
                if (cen16) begin
                    s3_over <= 1'b1;
                end
                // i/o and granted sound cycles ack at once, memory waits for busy
                if (!bus_cs || !bus_busy) begin
                    DTACKn <= 1'b0;
                end
            end
        end
    end

    // saturating fail counter
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            fail_cnt <= '0;
        end else if (stall_hit) begin
            if (fail_cnt > ({FAIL_W{1'b1}} - FAIL_W'(FAIL_STEP))) begin
                fail_cnt <= '1;     // pinned at max
            end else begin
                fail_cnt <= fail_cnt + FAIL_W'(FAIL_STEP);
            end
        end else if (short_wrap) begin
            fail_cnt <= fail_cnt - 1'b1;    // one short period repaid
        end
    end

endmodule

/* cps_bus_top.sv */
// main cpu bus timing top level tying decode, shared memory, sound grant and acknowledge together
`timescale 1ns/10ps

module cps_bus_top import cpu_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  cpu_bus_t    cpu,
    input  logic        qs_busak_n,
    output logic        DTACKn,
    output logic [15:0] rdata,
    output logic        cen16,
    output logic        cen16b,
    output logic        qs_busrq_n
);

    sel_t sel;          // region of the current cycle
    logic bus_busy;     // shared memory stall
    logic qs_busakn_s;  // grant in clk domain

    bus_region_decode u_decode (
        .cpu (cpu),
        .sel (sel)
    );

    mem_port u_mem (
        .clk      (clk),
        .rst      (rst),
        .cpu      (cpu),
        .mem_cs   (sel.mem_cs),
        .bus_busy (bus_busy),
        .rdata    (rdata)
    );

    qs_grant_sync u_qs_sync (
        .clk         (clk),
        .rst         (rst),
        .as_n        (cpu.as_n),
        .qs_cs       (sel.qs_cs),
        .qs_busak_n  (qs_busak_n),
        .qs_busrq_n  (qs_busrq_n),
        .qs_busakn_s (qs_busakn_s)
    );

    bus_dtack u_dtack (
        .clk         (clk),
        .rst         (rst),
        .as_n        (cpu.as_n),
        .bus_cs      (sel.mem_cs),
        .bus_busy    (bus_busy),
        .qs_cs       (sel.qs_cs),
        .qs_busakn_s (qs_busakn_s),
        .DTACKn      (DTACKn),
        .cen16       (cen16),
        .cen16b      (cen16b)
    );

endmodule

/* cps_bus_sva.sv */
// concurrent checks on acknowledge, clock enable and memory busy timing, bound into bus_dtack
`timescale 1ns/10ps

module cps_bus_sva import cpu_bus_pkg::*; (
    input logic clk,
    input logic rst,
    input logic as_n,
    input logic bus_cs,
    input logic bus_busy,
    input logic DTACKn,
    input logic cen16,
    input logic cen16b
);

    // cen16b always lands the cycle after cen16
    assert property (@(posedge clk) disable iff (rst) cen16 |=> cen16b)
        else $error("cen16b missing after cen16");

    // a new cycle starts with the acknowledge high
    assert property (@(posedge clk) disable iff (rst) $fell(as_n) |=> DTACKn)
        else $error("DTACKn low on the edge after as_n fell");

    // strobe release clears the acknowledge on the next edge
    assert property (@(posedge clk) disable iff (rst) $rose(as_n) |=> DTACKn)
        else $error("DTACKn still low after as_n rose");

    // no acknowledge while memory is still working
    assert property (@(posedge clk) disable iff (rst) (!as_n && bus_cs && bus_busy) |=> DTACKn)
        else $error("DTACKn low during a memory stall");

    // busy lasts at least the access latency
    assert property (@(posedge clk) disable iff (rst) $fell(bus_busy) |-> $past(bus_busy, MEM_LAT))
        else $error("bus_busy shorter than the memory latency");

endmodule

/* tb_cps_bus.sv */
// random-stimulus testbench for the cpu bus timing top, plays the 68000 side and the sound cpu grant
`timescale 1ns/10ps

module tb_cps_bus import cpu_bus_pkg::*; ();

    localparam int  MEM_OPS    = 400;   // back to back memory cycles
    localparam int  MIX_OPS    = 200;   // memory, i/o and sound mixed
    localparam int  IDLE_WIN   = 40;    // quiet bus after the memory burst
    localparam int  NUM_CYCLES = MEM_OPS + MIX_OPS + IDLE_WIN;
    localparam real CLK_PERIOD = 100.0;

    logic        clk = 1'b0;
    logic        rst;
    cpu_bus_t    cpu;
    logic        qs_busak_n;
    logic        DTACKn;
    logic [15:0] rdata;
    logic        cen16;
    logic        cen16b;
    logic        qs_busrq_n;

    logic [31:0] rnd;                               // cpu stimulus stream
    logic [31:0] grant_rnd;                         // sound side delay stream
    logic [15:0] ref_mem   [0:(1 << MEM_AW) - 1];   // model of the shared memory
    logic        ref_valid [0:(1 << MEM_AW) - 1];   // word written at least once
    int          cyc = 0;                           // rising edges seen
    int          data_errs = 0;
    int          bit_errs = 0;
    int          other_errs = 0;
    int          mon_errs = 0;
    logic        in_qs;                             // sound cycle in flight
    logic        run_mon = 1'b0;
    int          grant_cyc = -1;                    // edge count when grant dropped
    int          last_cen = -1;
    int          short_gaps = 0;                    // cen16 periods of 2
    logic        prev_cen16 = 1'b0;

    always #50 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    cps_bus_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .cpu        (cpu),
        .qs_busak_n (qs_busak_n),
        .DTACKn     (DTACKn),
        .rdata      (rdata),
        .cen16      (cen16),
        .cen16b     (cen16b),
        .qs_busrq_n (qs_busrq_n)
    );

    bind bus_dtack cps_bus_sva sva_i (
        .clk      (clk),
        .rst      (rst),
        .as_n     (as_n),
        .bus_cs   (bus_cs),
        .bus_busy (bus_busy),
        .DTACKn   (DTACKn),
        .cen16    (cen16),
        .cen16b   (cen16b)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // outputs settle on the edge, inputs move 5 ns later
    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic check_data(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) begin
            data_errs++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            bit_errs++;
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic report_fail(input string what);
        other_errs++;
        $display("%s, at cycle %0d", what, cyc);
    endtask

    task automatic print_counts();
        $display("errors: data %0d, strobe %0d, timing %0d, monitor %0d",
                 data_errs, bit_errs, other_errs, mon_errs);
    endtask

    // one 68000 style cycle, kind 0 memory, 1 i/o, 2 sound window
    task automatic bus_cycle(input int kind, input int idle);
        logic [23:1] addr;
        logic [31:0] r2;
        int          start;
        rnd = xorshift(rnd);
        r2  = xorshift(rnd ^ 32'h0000_5a5a);
        case (kind)
            0:       addr = {MEM_BASE, rnd[15:5], 3'b000, rnd[4:0]};  // 32 hot words
            1:       addr = {4'd1 + 4'(rnd[11:4] % 8'd14), rnd[30:12]};
            default: addr = {QS_BASE, rnd[30:12]};
        endcase
        cpu.addr  = addr;
        cpu.rw    = rnd[31];
        cpu.wdata = r2[15:0];
        cpu.as_n  = 1'b0;
        in_qs     = (kind == 2);
        start     = cyc;
        next_cycle();
        check_bit("dtack high on strobe edge", 1'b1, DTACKn);
        next_cycle();
        if (kind == 1) begin
            check_bit("io dtack two edges after strobe", 1'b0, DTACKn);
        end
        while (DTACKn) begin
            next_cycle();
        end
        if (kind == 0) begin
            // busy rises on edge 1, holds MEM_LAT cycles, dtack needs one more edge
            if (cyc - start < MEM_LAT + 2) begin
                report_fail("memory cycle acknowledged before the access latency ran out");
            end
            if (cpu.rw) begin
                if (ref_valid[addr[MEM_AW:1]]) begin
                    check_data("memory read", ref_mem[addr[MEM_AW:1]], rdata);
                end
            end else begin
                ref_mem[addr[MEM_AW:1]]   = cpu.wdata;
                ref_valid[addr[MEM_AW:1]] = 1'b1;
            end
        end else if (kind == 2) begin
            // grant crosses SYNC_STAGES flops, then the dtack register
            if (grant_cyc < start || cyc - grant_cyc < SYNC_STAGES + 1) begin
                report_fail("sound window acknowledged ahead of the synchronized grant");
            end
        end
        cpu.as_n = 1'b1;
        next_cycle();
        check_bit("dtack high after strobe release", 1'b1, DTACKn);
        in_qs = 1'b0;
        repeat (idle) next_cycle();
    endtask

    // sound cpu answers a request after 1 to 8 cycles
    initial begin : grant_proc
        int wait_cnt;
        qs_busak_n = 1'b1;
        grant_rnd  = 32'hf6d6 ^ 32'h9e37_79b9;     // own stream, off the same seed
        wait_cnt   = -1;
        forever begin
            next_cycle();
            if (!qs_busrq_n && qs_busak_n) begin
                if (wait_cnt < 0) begin
                    grant_rnd = xorshift(grant_rnd);
                    wait_cnt  = 1 + int'(grant_rnd[2:0]);
                end
                wait_cnt--;
                if (wait_cnt == 0) begin
                    qs_busak_n = 1'b0;
                    grant_cyc  = cyc;
                    wait_cnt   = -1;
                end
            end else if (qs_busrq_n && !qs_busak_n) begin
                qs_busak_n = 1'b1;      // request gone, bus handed back
            end
        end
    end

    // mid-cycle look at request level and enable spacing
    always @(negedge clk) begin
        if (run_mon) begin
            if (!qs_busrq_n && !in_qs) begin
                mon_errs++;
                $display("bus request low outside a sound window cycle, at cycle %0d", cyc);
            end
            if (cen16b !== prev_cen16) begin
                mon_errs++;
                $display("cen16b did not follow cen16 by one cycle, at cycle %0d", cyc);
            end
            if (cen16) begin
                if (last_cen >= 0 && (cyc - last_cen < 2 || cyc - last_cen > 3)) begin
                    mon_errs++;
                    $display("cen16 gap of %0d cycles, at cycle %0d", cyc - last_cen, cyc);
                end
                if (last_cen >= 0 && cyc - last_cen == 2) begin
                    short_gaps++;
                end
                last_cen = cyc;
            end
            prev_cen16 = cen16;
        end
    end

    initial begin : main_proc
        int kind;
        int total;
        rst      = 1'b1;
        cpu      = '0;
        cpu.as_n = 1'b1;
        in_qs    = 1'b0;
        rnd      = 32'hf6d6;
        for (int i = 0; i < (1 << MEM_AW); i++) begin
            ref_valid[i] = 1'b0;
        end
        repeat (2) begin
            next_cycle();
            check_bit("dtack in reset", 1'b1, DTACKn);
            check_bit("bus request in reset", 1'b1, qs_busrq_n);
            check_bit("cen16 in reset", 1'b0, cen16);
            check_bit("cen16b in reset", 1'b0, cen16b);
        end
        rst = 1'b0;
        next_cycle();
        check_bit("cen16b before first count", 1'b0, cen16b);
        run_mon = 1'b1;

        for (int i = 0; i < MEM_OPS; i++) begin
            bus_cycle(0, 0);    // strobe high for a single edge between cycles
        end
        short_gaps = 0;         // only periods on the idle bus count here
        repeat (IDLE_WIN) next_cycle();
        if (short_gaps == 0) begin
            report_fail("no shortened cen16 period after the memory burst");
        end

        for (int i = 0; i < MIX_OPS; i++) begin
            rnd  = xorshift(rnd);
            kind = int'(rnd[1:0] % 2'd3);
            bus_cycle(kind, 2 + int'(rnd[3:2]));   // two quiet cycles let the grant chain clear
        end
        repeat (4) next_cycle();

        total = data_errs + bit_errs + other_errs + mon_errs;
        print_counts();
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog
        #(CLK_PERIOD * 300.0 * NUM_CYCLES);
        $display("run hung, a bus cycle never got its acknowledge");
        print_counts();
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* project.f */
cpu_bus_pkg.sv
bus_region_decode.sv
mem_port.sv
qs_grant_sync.sv
bus_dtack.sv
cps_bus_top.sv
cps_bus_sva.sv
tb_cps_bus.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_cps_bus -o sim_cps_bus
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_cps_bus)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "NO ERRORS"; then
    exit 0
fi
exit 1
